/* verilog/show_pkg.sv */
package show_pkg;

	localparam int CUE_W     = 14;
	localparam int CUE_IDX_W = 5;
	localparam int NUM_LAMPS = 8;
	localparam int NUM_CUES  = 23; // last entry is the final play cue

	typedef enum logic [2:0] {
		NOTE_WHOLE,
		NOTE_HALF,
		NOTE_QUARTER,
		NOTE_EIGHTH,
		NOTE_16TH,
		NOTE_32ND,
		NOTE_64TH,
		NOTE_PAUSE // half minus a sixteenth
	} note_t;

	typedef enum logic [1:0] {
		GATE_FULL,
		GATE_FIRST_16,
		GATE_FIRST_8,
		GATE_AFTER_8
	} gate_t;

	typedef struct packed {
		logic                 kind; // 0
		logic [NUM_LAMPS-1:0] mask;
		note_t                note;
		gate_t                gate;
	} play_cue_t;

	typedef struct packed {
		logic                         kind; // 1
		logic [CUE_IDX_W-1:0]         target;
		logic [3:0]                   count;
		logic [CUE_W-CUE_IDX_W-6:0]   unused;
	} repeat_cue_t;

	typedef union packed {
		play_cue_t   play;
		repeat_cue_t rpt;
	} cue_word_t;

	// lamps lit for a mask under a gate, t_ms into the step
	function automatic logic [NUM_LAMPS-1:0] gated_mask(
		input logic [NUM_LAMPS-1:0] mask,
		input gate_t                gate,
		input logic [15:0]          t_ms,
		input logic [15:0]          bound_ms
	);
		logic [NUM_LAMPS-1:0] m;
		case (gate)
			GATE_FULL:                   m = mask;
			GATE_FIRST_16, GATE_FIRST_8: m = (t_ms < bound_ms) ? mask : '0;
			default:                     m = (t_ms > bound_ms) ? mask : '0;
		endcase
		return m;
	endfunction

endpackage

/* verilog/show_if.sv */
`timescale 1ns/10ps

interface show_if;
	import show_pkg::*;

	logic [15:0]          dur_ms;
	logic                 restart;
	logic [15:0]          elapsed_ms;
	logic                 step_end;
	logic [NUM_LAMPS-1:0] lamp_mask;
	gate_t                gate;
	logic                 lamps_on;
	logic [15:0]          gate_ms; // gate boundary

	modport seq (
		output dur_ms, restart, lamp_mask, gate, lamps_on, gate_ms,
		input  step_end
	);

	modport tmr (
		output elapsed_ms, step_end,
		input  dur_ms, restart
	);

	modport mix (
		input lamp_mask, gate, lamps_on, gate_ms, elapsed_ms
	);

endinterface

/* verilog/ms_timer.sv */
`timescale 1ns/10ps

module ms_timer #(
	parameter int CLKS_PER_MS = 50000
) (
	input  logic clk,
	input  logic rst_n,
	show_if.tmr  step
);

	localparam int PRE_W = (CLKS_PER_MS > 1) ? $clog2(CLKS_PER_MS) : 1;
	localparam logic [PRE_W-1:0] PRE_LAST = PRE_W'(CLKS_PER_MS - 1);

	logic [PRE_W-1:0] presc;
	logic             tick;

	assign tick = (presc == PRE_LAST);

	// millisecond prescaler
	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			presc <= '0;
		else if (step.restart || tick)
			presc <= '0;
		else
			presc <= presc + 1'b1;
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			step.elapsed_ms <= '0;
		else if (step.restart)
			step.elapsed_ms <= '0;
		else if (tick)
			step.elapsed_ms <= step.elapsed_ms + 16'd1;
	end

	// sequencer restarts on this, so it lasts one clock
	assign step.step_end = (step.elapsed_ms == step.dur_ms);

endmodule

/* verilog/cue_rom.sv */
`timescale 1ns/10ps

module cue_rom (
	input  logic [show_pkg::CUE_IDX_W-1:0] index,
	output show_pkg::cue_word_t            cue
);
	import show_pkg::*;

	function automatic cue_word_t cue_play(
		input logic [NUM_LAMPS-1:0] m,
		input note_t                n,
		input gate_t                g
	);
		cue_word_t w;
		w.play = '{kind: 1'b0, mask: m, note: n, gate: g};
		return w;
	endfunction

	function automatic cue_word_t cue_repeat(
		input logic [CUE_IDX_W-1:0] t,
		input logic [3:0]           c
	);
		cue_word_t w;
		w.rpt = '{kind: 1'b1, target: t, count: c, unused: '0};
		return w;
	endfunction

	always_comb begin
		case (index)
			5'd0:  cue = cue_play(8'h02, NOTE_WHOLE, GATE_FULL); // intro
			5'd1:  cue = cue_play(8'h10, NOTE_WHOLE, GATE_FULL);
			5'd2:  cue = cue_play(8'h04, NOTE_WHOLE, GATE_FULL);
			5'd3:  cue = cue_play(8'h08, NOTE_WHOLE, GATE_FULL);
			5'd4:  cue = cue_play(8'h02, NOTE_HALF, GATE_FULL);
			5'd5:  cue = cue_play(8'h04, NOTE_HALF, GATE_FULL);
			5'd6:  cue = cue_play(8'h08, NOTE_HALF, GATE_FULL);
			5'd7:  cue = cue_play(8'h10, NOTE_HALF, GATE_FULL);
			// building chords
			5'd8:  cue = cue_play(8'h02, NOTE_QUARTER, GATE_FULL);
			5'd9:  cue = cue_play(8'h06, NOTE_QUARTER, GATE_FULL);
			5'd10: cue = cue_play(8'h0e, NOTE_QUARTER, GATE_FULL);
			5'd11: cue = cue_play(8'h1e, NOTE_QUARTER, GATE_FULL);
			5'd12: cue = cue_play(8'h40, NOTE_16TH, GATE_FULL); // bass drop
			5'd13: cue = cue_play(8'h00, NOTE_16TH, GATE_FULL);
			5'd14: cue = cue_repeat(5'd12, 4'd1);
			5'd15: cue = cue_play(8'h40, NOTE_32ND, GATE_FULL);
			5'd16: cue = cue_play(8'h00, NOTE_32ND, GATE_FULL);
			5'd17: cue = cue_repeat(5'd15, 4'd3);
			5'd18: cue = cue_play(8'h00, NOTE_PAUSE, GATE_FULL);
			// gated phrase, lamp 7 is the accent
			5'd19: cue = cue_play(8'h58, NOTE_QUARTER, GATE_FIRST_16);
			5'd20: cue = cue_play(8'h06, NOTE_QUARTER, GATE_FULL);
			5'd21: cue = cue_play(8'h98, NOTE_QUARTER, GATE_FIRST_8);
			5'd22: cue = cue_play(8'h46, NOTE_QUARTER, GATE_AFTER_8);
			default: cue = cue_play(8'h00, NOTE_QUARTER, GATE_FULL);
		endcase
	end

endmodule

/* verilog/cue_sequencer.sv */
`timescale 1ns/10ps

module cue_sequencer #(
	parameter int QUARTER_MS     = 429,
	parameter int START_DELAY_MS = 2000
) (
	input  logic clk,
	input  logic rst_n,
	input  logic go,
	output logic finished,
	show_if.seq  step
);
	import show_pkg::*;

	localparam logic [2:0] S_IDLE  = 3'd0;
	localparam logic [2:0] S_DELAY = 3'd1;
	localparam logic [2:0] S_PLAY  = 3'd2;
	localparam logic [2:0] S_HOLD  = 3'd3;
	localparam logic [2:0] S_DONE  = 3'd4;

	localparam logic [15:0] Q_MS     = 16'(QUARTER_MS);
	localparam logic [15:0] START_MS = 16'(START_DELAY_MS);
	localparam logic [CUE_IDX_W-1:0] LAST_CUE = CUE_IDX_W'(NUM_CUES - 1);

	logic [2:0]           state, state_nxt;
	logic [CUE_IDX_W-1:0] cue_idx, cue_idx_nxt;
	logic [3:0]           loop_cnt, loop_cnt_nxt;
	cue_word_t            cue;
	logic [15:0]          note_ms;
	logic [15:0]          gate_ms;
	logic [NUM_LAMPS-1:0] end_mask; // what the last play step showed at its end

	cue_rom u_rom (
		.index(cue_idx),
		.cue  (cue)
	);

	always_comb begin
		case (cue.play.note)
			NOTE_WHOLE:   note_ms = Q_MS * 16'd4;
			NOTE_HALF:    note_ms = Q_MS * 16'd2;
			NOTE_QUARTER: note_ms = Q_MS;
			NOTE_EIGHTH:  note_ms = Q_MS / 16'd2;
			NOTE_16TH:    note_ms = Q_MS / 16'd4;
			NOTE_32ND:    note_ms = Q_MS / 16'd8;
			NOTE_64TH:    note_ms = Q_MS / 16'd16;
			default:      note_ms = Q_MS * 16'd2 - Q_MS / 16'd4;
		endcase
	end

	always_comb begin
		case (cue.play.gate)
			GATE_FIRST_16:              gate_ms = Q_MS / 16'd4;
			GATE_FIRST_8, GATE_AFTER_8: gate_ms = Q_MS / 16'd2;
			default:                    gate_ms = '0;
		endcase
	end

	always_comb begin
		state_nxt      = state;
		cue_idx_nxt    = cue_idx;
		loop_cnt_nxt   = loop_cnt;
		step.restart   = 1'b0;
		step.dur_ms    = note_ms;
		step.lamp_mask = cue.play.mask;
		step.gate      = cue.play.gate;
		step.gate_ms   = gate_ms;
		step.lamps_on  = 1'b0;
		case (state)
			S_IDLE: begin
				step.restart = 1'b1;
				if (go) begin
					state_nxt    = S_DELAY;
					cue_idx_nxt  = '0;
					loop_cnt_nxt = '0;
				end
			end
			S_DELAY: begin
				step.dur_ms = START_MS;
				if (step.step_end) begin
					step.restart = 1'b1;
					state_nxt    = S_PLAY;
				end
			end
			S_PLAY: begin
				step.lamps_on = 1'b1;
				if (!cue.play.kind) begin
					if (step.step_end) begin
						step.restart = 1'b1;
						if (cue_idx == LAST_CUE)
							state_nxt = S_HOLD;
						else
							cue_idx_nxt = cue_idx + 1'b1;
					end
				end else begin
					// repeat cue, one clock, lamps frozen
					step.restart   = 1'b1;
					step.dur_ms    = '1;
					step.lamp_mask = end_mask;
					step.gate      = GATE_FULL;
					if (loop_cnt < cue.rpt.count) begin
						loop_cnt_nxt = loop_cnt + 1'b1;
						cue_idx_nxt  = cue.rpt.target;
					end else begin
						loop_cnt_nxt = '0;
						cue_idx_nxt  = cue_idx + 1'b1;
					end
				end
			end
			S_HOLD: begin
				step.lamps_on  = 1'b1;
				step.dur_ms    = Q_MS;
				step.lamp_mask = '1; // all on
				step.gate      = GATE_FULL;
				if (step.step_end) begin
					step.restart = 1'b1;
					state_nxt    = S_DONE;
				end
			end
			S_DONE: begin
				step.restart = 1'b1;
				state_nxt    = S_IDLE;
			end
			default: state_nxt = S_IDLE;
		endcase
	end

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n) begin
			state    <= S_IDLE;
			cue_idx  <= '0;
			loop_cnt <= '0;
		end else begin
			state    <= state_nxt;
			cue_idx  <= cue_idx_nxt;
			loop_cnt <= loop_cnt_nxt;
		end
	end

	always_ff @(posedge clk) begin
		if (state == S_PLAY && !cue.play.kind)
			end_mask <= gated_mask(cue.play.mask, cue.play.gate, note_ms, gate_ms);
	end

	assign finished = (state == S_DONE);

endmodule

/* verilog/light_mixer.sv */
`timescale 1ns/10ps

module light_mixer (
	input  logic                           clk,
	input  logic                           rst_n,
	show_if.mix                            step,
	output logic [show_pkg::NUM_LAMPS-1:0] lamps
);
	import show_pkg::*;

	logic [NUM_LAMPS-1:0] lamps_nxt;

	// dark outside play and hold
	assign lamps_nxt = step.lamps_on ?
		gated_mask(step.lamp_mask, step.gate, step.elapsed_ms, step.gate_ms) : '0;

	always_ff @(posedge clk, negedge rst_n) begin
		if (!rst_n)
			lamps <= '0;
		else
			lamps <= lamps_nxt;
	end

endmodule

/* verilog/show_top.sv */
`timescale 1ns/10ps

module show_top #(
	parameter int CLKS_PER_MS    = 50000,
	parameter int QUARTER_MS     = 429, // 140 bpm
	parameter int START_DELAY_MS = 2000
) (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           go,
	output logic                           finished,
	output logic [show_pkg::NUM_LAMPS-1:0] lamps
);

	show_if step_bus ();

	ms_timer #(
		.CLKS_PER_MS(CLKS_PER_MS)
	) u_timer (
		.clk  (clk),
		.rst_n(rst_n),
		.step (step_bus.tmr)
	);

	cue_sequencer #(
		.QUARTER_MS    (QUARTER_MS),
		.START_DELAY_MS(START_DELAY_MS)
	) u_seq (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.finished(finished),
		.step    (step_bus.seq)
	);

	light_mixer u_mix (
		.clk  (clk),
		.rst_n(rst_n),
		.step (step_bus.mix),
		.lamps(lamps)
	);

endmodule

/* tb/show_asserts.sv */
`timescale 1ns/10ps

module show_asserts (
	input logic                           clk,
	input logic                           rst_n,
	input logic                           finished,
	input logic [show_pkg::NUM_LAMPS-1:0] lamps,
	input logic [2:0]                     seq_state,
	input logic                           step_end,
	input logic [15:0]                    dur_ms
);

	localparam logic [2:0] SEQ_IDLE = 3'd0;
	localparam logic [2:0] SEQ_PLAY = 3'd2;

	finished_one_clock: assert property (
		@(posedge clk) disable iff (!rst_n) finished |=> !finished
	) else $error("finished stayed high for more than one clock");

	dark_in_idle: assert property (
		@(posedge clk) disable iff (!rst_n) (seq_state == SEQ_IDLE) |-> (lamps == '0)
	) else $error("lamps lit while the sequencer is idle");

	// zero length would end a play step before its first tick
	no_empty_step: assert property (
		@(posedge clk) disable iff (!rst_n)
			(seq_state == SEQ_PLAY && step_end) |-> (dur_ms != 16'd0)
	) else $error("play step ended with zero length");

endmodule

bind show_top show_asserts u_asserts (
	.clk      (clk),
	.rst_n    (rst_n),
	.finished (finished),
	.lamps    (lamps),
	.seq_state(u_seq.state),
	.step_end (step_bus.step_end),
	.dur_ms   (step_bus.dur_ms)
);

/* tb/show_tb.sv */
`timescale 1ns/10ps

module show_tb;

	localparam int CLKS_PER_MS    = 4;
	localparam int QUARTER_MS     = 16;
	localparam int START_DELAY_MS = 20;
	localparam int DELAY_CLKS     = START_DELAY_MS * CLKS_PER_MS;
	localparam int STEP_TIMEOUT   = 1000; // clocks, well above the longest step
	localparam int STIM_DEPTH     = 128;

	logic       clk;
	logic       rst_n;
	logic       go;
	logic       finished;
	logic [7:0] lamps;

	logic [11:0] stim [0:STIM_DEPTH-1];
	logic [7:0]  seen_q [$];
	logic [7:0]  last_lamps;
	int          fin_pulses;
	int          fin_len;
	int          fin_run; // clocks of the finished pulse in progress
	bit          verdict_given;

	show_top #(
		.CLKS_PER_MS   (CLKS_PER_MS),
		.QUARTER_MS    (QUARTER_MS),
		.START_DELAY_MS(START_DELAY_MS)
	) UUT (
		.clk     (clk),
		.rst_n   (rst_n),
		.go      (go),
		.finished(finished),
		.lamps   (lamps)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// lamp changes and finished pulses sampled between edges
	always @(negedge clk) begin
		if (rst_n) begin
			if (lamps !== last_lamps) begin
				seen_q.push_back(lamps);
				last_lamps = lamps;
			end
			if (finished) begin
				if (fin_run == 0)
					fin_pulses++;
				fin_run++;
			end else if (fin_run != 0) begin
				fin_len = fin_run;
				fin_run = 0;
			end
		end
	end

	task automatic report_failure(input string why);
		verdict_given = 1'b1;
		$display("%s", why);
		$display("TEST RESULT: FAIL");
		$fatal(1, "simulation stopped at %0t", $time);
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected)
			report_failure($sformatf("FAILED %s: expected %0h, actual %0h",
				name, expected, actual));
	endtask

	// next recorded lamp value and the clocks spent waiting for it
	task automatic wait_change(output logic [7:0] value, output int waited);
		int n;
		n = 0;
		while (seen_q.size() == 0 && n < STEP_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		waited = n;
		if (seen_q.size() == 0)
			report_failure("timed out waiting for the lamps to change");
		else
			value = seen_q.pop_front();
	endtask

	task automatic start_run();
		fin_pulses = 0;
		fin_len    = 0;
		go = 1'b1;
		@(negedge clk);
		go = 1'b0;
	endtask

	task automatic end_run(input int run);
		check_value($sformatf("run %0d finished pulses", run), 32'd1, fin_pulses);
		check_value($sformatf("run %0d finished length", run), 32'd1, fin_len);
	endtask

	initial begin
		int          idx;
		int          run;
		int          pos;
		int          waited;
		logic [7:0]  got;
		logic [11:0] entry;
		bit          done;

		rst_n         = 1'b0;
		go            = 1'b0;
		last_lamps    = '0;
		fin_pulses    = 0;
		fin_len       = 0;
		fin_run       = 0;
		verdict_given = 1'b0;
		$readmemh("tb/show_stimulus.txt", stim);
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		@(negedge clk);
		check_value("reset lamps", 32'd0, {24'd0, lamps});
		check_value("reset finished", 32'd0, {31'd0, finished});

		idx  = 0;
		run  = 0;
		pos  = 0;
		done = 1'b0;
		while (!done && idx < STIM_DEPTH) begin
			entry = stim[idx];
			idx++;
			case (entry[11:8])
				4'h1: begin
					if (run > 0)
						end_run(run);
					run++;
					pos = 0;
					start_run();
				end
				4'h0: begin
					wait_change(got, waited);
					if (pos == 0) // lamps dark for the whole start delay
						check_value($sformatf("run %0d start delay", run), 32'd1,
							{31'd0, waited >= DELAY_CLKS});
					check_value($sformatf("run %0d lamp change %0d", run, pos),
						{24'd0, entry[7:0]}, {24'd0, got});
					pos++;
				end
				4'hf: begin
					if (run > 0)
						end_run(run);
					done = 1'b1;
				end
				default: report_failure($sformatf("unknown stimulus entry %0h", entry));
			endcase
		end
		if (!done) begin
			report_failure("stimulus file has no end marker");
		end else begin
			verdict_given = 1'b1;
			$display("TEST RESULT: PASS");
			$finish;
		end
	end

	final begin
		if (!verdict_given)
			$display("TEST RESULT: FAIL");
	end

endmodule

/* tb/show_stimulus.txt */
// one hex word per entry: 1xx starts a run with a go pulse, 0xx is the next lamp value xx
// f00 ends the stimulus
100
002 010 004 008 // intro, whole notes
002 004 008 010 // intro, half notes
002 006 00e 01e // building chords
040 000 040 000 // bass drop, sixteenths twice
040 000 040 000 040 000 040 000 // bass drop, thirty-seconds four times
058 000 006 // accent only in the first sixteenth
098 000 046 // first eighth, then after eighth
0ff 000 // all-on hold, then dark
100
002 010 004 008
002 004 008 010
002 006 00e 01e
040 000 040 000
040 000 040 000 040 000 040 000
058 000 006
098 000 046
0ff 000
f00

/* verilog.f */
verilog/show_pkg.sv
verilog/show_if.sv
verilog/ms_timer.sv
verilog/cue_rom.sv
verilog/cue_sequencer.sv
verilog/light_mixer.sv
verilog/show_top.sv
tb/show_asserts.sv
tb/show_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= show_tb
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
